// ==== files.f ====
rtl/isa_pkg.sv
rtl/bus_pkg.sv
rtl/mem_stage.sv
rtl/fetch_unit.sv
rtl/wb_arbiter.sv
rtl/wb_ram.sv
rtl/mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    localparam int WB_ADDR_W = 30;  // Word address
    localparam int WB_DATA_W = 32;
    localparam int WB_SEL_W  = 4;

    // Memory map
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = $clog2(RAM_WORDS);
    localparam logic [WB_ADDR_W-1:0] IO_BASE = 30'h3FFF_C000;  // IO word 0

    // Read value substituted on err
    localparam logic [WB_DATA_W-1:0] BUS_ERR_VALUE = 32'h1337_1337;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit
    import bus_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_fetch_req,
    input  wire  [WB_ADDR_W-1:0] i_fetch_addr,
    output logic                 o_fetch_valid,
    output logic [WB_DATA_W-1:0] o_fetch_data,
    output logic                 o_fetch_busy,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic [WB_ADDR_W-1:0] o_wb_addr,
    output logic [WB_DATA_W-1:0] o_wb_wdata,
    output logic [WB_SEL_W-1:0]  o_wb_sel,
    input  wire                  i_wb_ack,
    input  wire                  i_wb_err,
    input  wire                  i_wb_stall,
    input  wire  [WB_DATA_W-1:0] i_wb_rdata
);

    typedef enum logic [1:0] {F_IDLE, F_STROBE, F_WAIT} fstate_e;

    fstate_e state;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state         <= F_IDLE;
            o_fetch_valid <= 1'b0;
        end else begin
            o_fetch_valid <= 1'b0;
            case (state)
                F_IDLE:   if (i_fetch_req) state <= F_STROBE;
                F_STROBE: if (!i_wb_stall) state <= F_WAIT;
                F_WAIT: begin
                    if (i_wb_ack || i_wb_err) begin
                        state         <= F_IDLE;
                        o_fetch_valid <= 1'b1;
                    end
                end
                default: state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == F_IDLE && i_fetch_req)
            o_wb_addr <= i_fetch_addr;
        if (state == F_WAIT)
            o_fetch_data <= i_wb_err ? BUS_ERR_VALUE : i_wb_rdata;
    end

    assign o_fetch_busy = (state != F_IDLE);
    assign o_wb_cyc     = (state != F_IDLE);
    assign o_wb_stb     = (state == F_STROBE);
    assign o_wb_we      = 1'b0;   // Read only master
    assign o_wb_wdata   = '0;
    assign o_wb_sel     = '1;

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

    // Destination register index, 0 means no write
    localparam int REG_W = 4;

    // Memory-side opcodes of the processor, other values pass through as non-memory
    typedef enum logic [4:0] {
        OP_NOP  = 5'h00,
        OP_CALL = 5'h0D,
        OP_RET  = 5'h0E,
        OP_LBSE = 5'h0F,
        OP_IN   = 5'h10,
        OP_OUT  = 5'h11,
        OP_LB   = 5'h12,
        OP_SB   = 5'h13,
        OP_LW   = 5'h14,
        OP_SW   = 5'h15
    } opcode_e;

endpackage

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage
    import isa_pkg::*, bus_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_pipe_stall,
    input  wire                  i_pipe_flush,
    output logic                 o_pipe_stall,
    output logic                 o_pipe_flush,
    input  opcode_e              i_opcode,
    input  wire  [REG_W-1:0]     i_dr,
    input  wire  [WB_DATA_W-1:0] i_sr1_val,
    input  wire  [WB_DATA_W-1:0] i_sr2_val,
    input  wire  [WB_DATA_W-1:0] i_imm,
    input  wire  [WB_DATA_W-1:0] i_pc,
    output logic                 o_wb_cyc,
    output logic                 o_wb_stb,
    output logic                 o_wb_we,
    output logic [WB_ADDR_W-1:0] o_wb_addr,
    output logic [WB_DATA_W-1:0] o_wb_wdata,
    output logic [WB_SEL_W-1:0]  o_wb_sel,
    input  wire                  i_wb_ack,
    input  wire                  i_wb_err,
    input  wire                  i_wb_stall,
    input  wire  [WB_DATA_W-1:0] i_wb_rdata,
    output logic [REG_W-1:0]     o_fwd_dr,
    output logic [WB_DATA_W-1:0] o_fwd_val,
    output logic [REG_W-1:0]     o_buf_dr,
    output logic [WB_DATA_W-1:0] o_buf_val,
    output logic                 o_ld_newpc,
    output logic [WB_DATA_W-1:0] o_br_pc
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_STROBE,
        S_WAIT,
        S_HELD,    // Answer in, pipeline still stalled
        S_RESULT
    } state_e;

    state_e state;

    logic                 start_tx, is_io, is_byte, is_wr;
    logic [WB_ADDR_W-1:0] io_addr;
    logic [WB_DATA_W-1:0] mem_addr;   // Byte address
    logic [WB_DATA_W-1:0] wr_data;
    logic [WB_SEL_W-1:0]  sel;

    // Latched instruction
    opcode_e              op_q;
    logic [REG_W-1:0]     dr_q;
    logic [1:0]           lane_q;
    logic [WB_DATA_W-1:0] tgt_q;      // CALL target
    logic [WB_DATA_W-1:0] res_q;

    logic [7:0]           rd_byte;
    logic [WB_DATA_W-1:0] rd_val;
    logic                 answer, res_cyc, is_load_q, is_jump_q;

    // Decode of the incoming instruction
    assign start_tx = i_opcode inside {OP_LW, OP_SW, OP_LB, OP_LBSE, OP_SB,
                                       OP_IN, OP_OUT, OP_CALL, OP_RET};
    assign is_io    = i_opcode inside {OP_IN, OP_OUT};
    assign is_byte  = i_opcode inside {OP_LB, OP_LBSE, OP_SB};
    assign is_wr    = i_opcode inside {OP_SW, OP_SB, OP_OUT, OP_CALL};

    // IO sits at the top of the map, imm picks the IO word
    assign io_addr = IO_BASE + WB_ADDR_W'(i_imm[13:0]);

    always_comb begin
        if (is_io)
            mem_addr = {io_addr, 2'b00};
        else if (i_opcode == OP_CALL)
            mem_addr = i_sr2_val - 32'd4;  // Push return address
        else if (i_opcode == OP_RET)
            mem_addr = i_sr2_val;
        else
            mem_addr = i_sr1_val + i_imm;
    end

    always_comb begin
        sel = is_byte ? WB_SEL_W'(1) << mem_addr[1:0] : '1;
        if (i_opcode == OP_CALL)
            wr_data = i_pc + 32'd4;
        else if (is_io)
            wr_data = i_sr1_val;
        else if (is_byte)
            wr_data = i_sr2_val << {mem_addr[1:0], 3'b000};  // Move byte to its lane
        else
            wr_data = i_sr2_val;
    end

    // Read data path, byte extraction and err substitution
    assign rd_byte = i_wb_rdata[{lane_q, 3'b000} +: 8];

    always_comb begin
        if (i_wb_err)
            rd_val = BUS_ERR_VALUE;
        else if (op_q == OP_LBSE)
            rd_val = {{(WB_DATA_W-8){rd_byte[7]}}, rd_byte};
        else if (op_q == OP_LB)
            rd_val = {{(WB_DATA_W-8){1'b0}}, rd_byte};
        else
            rd_val = i_wb_rdata;
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start_tx && !i_pipe_stall && !i_pipe_flush)
                        state <= S_STROBE;
                end
                S_STROBE: begin
                    if (!i_wb_stall)
                        state <= S_WAIT;
                    else if (i_pipe_flush)
                        state <= S_IDLE;  // Not yet accepted, safe to drop
                end
                S_WAIT: begin
                    if (answer)
                        state <= i_pipe_stall ? S_HELD : S_RESULT;
                end
                S_HELD: begin
                    if (!i_pipe_stall)
                        state <= S_RESULT;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Payload follows the instruction while idle
    always_ff @(posedge i_clk) begin
        if (state == S_IDLE) begin
            op_q       <= i_opcode;
            dr_q       <= i_dr;
            lane_q     <= mem_addr[1:0];
            tgt_q      <= i_sr1_val + i_imm;
            o_wb_addr  <= mem_addr[WB_DATA_W-1:2];
            o_wb_wdata <= wr_data;
            o_wb_sel   <= sel;
            o_wb_we    <= is_wr;
        end
        if (answer)
            res_q <= rd_val;
    end

    assign o_wb_cyc = (state == S_STROBE) || (state == S_WAIT);
    assign o_wb_stb = (state == S_STROBE);

    assign answer    = (state == S_WAIT) && (i_wb_ack || i_wb_err);
    assign res_cyc   = (state == S_RESULT);
    assign is_load_q = op_q inside {OP_LW, OP_LB, OP_LBSE, OP_IN};
    assign is_jump_q = op_q inside {OP_CALL, OP_RET};

    always_comb begin
        if (state == S_IDLE)
            o_pipe_stall = i_pipe_stall || (start_tx && !i_pipe_flush);
        else
            o_pipe_stall = i_pipe_stall || !res_cyc;
    end

    // Forward straight from the bus when the pipe can take it
    assign o_fwd_dr  = (answer && !i_pipe_stall && is_load_q) ? dr_q : '0;
    assign o_fwd_val = (answer && !i_pipe_stall && is_load_q) ? rd_val : '0;

    assign o_buf_dr     = (res_cyc && is_load_q) ? dr_q : '0;
    assign o_buf_val    = (res_cyc && is_load_q) ? res_q : '0;
    assign o_ld_newpc   = res_cyc && is_jump_q;
    assign o_pipe_flush = o_ld_newpc;
    assign o_br_pc      = !o_ld_newpc ? '0 : (op_q == OP_CALL) ? tgt_q : res_q;

endmodule

`default_nettype wire

// ==== rtl/mem_subsystem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem_top
    import isa_pkg::*, bus_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_pipe_stall,
    input  wire                  i_pipe_flush,
    output logic                 o_pipe_stall,
    output logic                 o_pipe_flush,
    input  opcode_e              i_opcode,
    input  wire  [REG_W-1:0]     i_dr,
    input  wire  [WB_DATA_W-1:0] i_sr1_val,
    input  wire  [WB_DATA_W-1:0] i_sr2_val,
    input  wire  [WB_DATA_W-1:0] i_imm,
    input  wire  [WB_DATA_W-1:0] i_pc,
    output logic [REG_W-1:0]     o_fwd_dr,
    output logic [WB_DATA_W-1:0] o_fwd_val,
    output logic [REG_W-1:0]     o_buf_dr,
    output logic [WB_DATA_W-1:0] o_buf_val,
    output logic                 o_ld_newpc,
    output logic [WB_DATA_W-1:0] o_br_pc,
    input  wire                  i_fetch_req,
    input  wire  [WB_ADDR_W-1:0] i_fetch_addr,
    output logic                 o_fetch_valid,
    output logic [WB_DATA_W-1:0] o_fetch_data,
    output logic                 o_fetch_busy,
    input  wire  [WB_DATA_W-1:0] i_io_in,
    output logic [WB_DATA_W-1:0] o_io_out
);

    // Master 0 is the memory stage, master 1 the fetch unit
    logic                 m0_cyc, m0_stb, m0_we, m0_ack, m0_err, m0_stall;
    logic [WB_ADDR_W-1:0] m0_addr;
    logic [WB_DATA_W-1:0] m0_wdata, m0_rdata;
    logic [WB_SEL_W-1:0]  m0_sel;
    logic                 m1_cyc, m1_stb, m1_we, m1_ack, m1_err, m1_stall;
    logic [WB_ADDR_W-1:0] m1_addr;
    logic [WB_DATA_W-1:0] m1_wdata, m1_rdata;
    logic [WB_SEL_W-1:0]  m1_sel;
    logic                 s_cyc, s_stb, s_we, s_ack, s_err;
    logic [WB_ADDR_W-1:0] s_addr;
    logic [WB_DATA_W-1:0] s_wdata, s_rdata;
    logic [WB_SEL_W-1:0]  s_sel;

    mem_stage mem_stage_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_pipe_stall(i_pipe_stall), .i_pipe_flush(i_pipe_flush),
        .o_pipe_stall(o_pipe_stall), .o_pipe_flush(o_pipe_flush),
        .i_opcode(i_opcode), .i_dr(i_dr), .i_pc(i_pc),
        .i_sr1_val(i_sr1_val), .i_sr2_val(i_sr2_val), .i_imm(i_imm),
        .o_wb_cyc(m0_cyc), .o_wb_stb(m0_stb), .o_wb_we(m0_we),
        .o_wb_addr(m0_addr), .o_wb_wdata(m0_wdata), .o_wb_sel(m0_sel),
        .i_wb_ack(m0_ack), .i_wb_err(m0_err), .i_wb_stall(m0_stall),
        .i_wb_rdata(m0_rdata),
        .o_fwd_dr(o_fwd_dr), .o_fwd_val(o_fwd_val),
        .o_buf_dr(o_buf_dr), .o_buf_val(o_buf_val),
        .o_ld_newpc(o_ld_newpc), .o_br_pc(o_br_pc)
    );

    fetch_unit fetch_unit_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_fetch_req(i_fetch_req), .i_fetch_addr(i_fetch_addr),
        .o_fetch_valid(o_fetch_valid), .o_fetch_data(o_fetch_data),
        .o_fetch_busy(o_fetch_busy),
        .o_wb_cyc(m1_cyc), .o_wb_stb(m1_stb), .o_wb_we(m1_we),
        .o_wb_addr(m1_addr), .o_wb_wdata(m1_wdata), .o_wb_sel(m1_sel),
        .i_wb_ack(m1_ack), .i_wb_err(m1_err), .i_wb_stall(m1_stall),
        .i_wb_rdata(m1_rdata)
    );

    wb_arbiter wb_arbiter_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_m0_cyc(m0_cyc), .i_m0_stb(m0_stb), .i_m0_we(m0_we),
        .i_m0_addr(m0_addr), .i_m0_wdata(m0_wdata), .i_m0_sel(m0_sel),
        .o_m0_ack(m0_ack), .o_m0_err(m0_err), .o_m0_stall(m0_stall),
        .o_m0_rdata(m0_rdata),
        .i_m1_cyc(m1_cyc), .i_m1_stb(m1_stb), .i_m1_we(m1_we),
        .i_m1_addr(m1_addr), .i_m1_wdata(m1_wdata), .i_m1_sel(m1_sel),
        .o_m1_ack(m1_ack), .o_m1_err(m1_err), .o_m1_stall(m1_stall),
        .o_m1_rdata(m1_rdata),
        .o_s_cyc(s_cyc), .o_s_stb(s_stb), .o_s_we(s_we),
        .o_s_addr(s_addr), .o_s_wdata(s_wdata), .o_s_sel(s_sel),
        .i_s_ack(s_ack), .i_s_err(s_err), .i_s_rdata(s_rdata)
    );

    wb_ram wb_ram_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_wb_cyc(s_cyc), .i_wb_stb(s_stb), .i_wb_we(s_we),
        .i_wb_addr(s_addr), .i_wb_wdata(s_wdata), .i_wb_sel(s_sel),
        .i_io_in(i_io_in),
        .o_wb_ack(s_ack), .o_wb_err(s_err), .o_wb_rdata(s_rdata),
        .o_io_out(o_io_out)
    );

endmodule

`default_nettype wire

// ==== rtl/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter
    import bus_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    // Master 0, memory stage
    input  wire                  i_m0_cyc,
    input  wire                  i_m0_stb,
    input  wire                  i_m0_we,
    input  wire  [WB_ADDR_W-1:0] i_m0_addr,
    input  wire  [WB_DATA_W-1:0] i_m0_wdata,
    input  wire  [WB_SEL_W-1:0]  i_m0_sel,
    output logic                 o_m0_ack,
    output logic                 o_m0_err,
    output logic                 o_m0_stall,
    output logic [WB_DATA_W-1:0] o_m0_rdata,
    // Master 1, fetch
    input  wire                  i_m1_cyc,
    input  wire                  i_m1_stb,
    input  wire                  i_m1_we,
    input  wire  [WB_ADDR_W-1:0] i_m1_addr,
    input  wire  [WB_DATA_W-1:0] i_m1_wdata,
    input  wire  [WB_SEL_W-1:0]  i_m1_sel,
    output logic                 o_m1_ack,
    output logic                 o_m1_err,
    output logic                 o_m1_stall,
    output logic [WB_DATA_W-1:0] o_m1_rdata,
    // Slave side
    output logic                 o_s_cyc,
    output logic                 o_s_stb,
    output logic                 o_s_we,
    output logic [WB_ADDR_W-1:0] o_s_addr,
    output logic [WB_DATA_W-1:0] o_s_wdata,
    output logic [WB_SEL_W-1:0]  o_s_sel,
    input  wire                  i_s_ack,
    input  wire                  i_s_err,
    input  wire  [WB_DATA_W-1:0] i_s_rdata
);

    logic owner_q;   // 1 when fetch owns the bus
    logic busy_q;
    logic hold, gnt1;

    // Owner keeps the bus while its cyc stays up
    assign hold = busy_q && (owner_q ? i_m1_cyc : i_m0_cyc);
    assign gnt1 = hold ? owner_q : (!i_m0_cyc && i_m1_cyc);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            owner_q <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            owner_q <= gnt1;
            busy_q  <= gnt1 ? i_m1_cyc : i_m0_cyc;
        end
    end

    assign o_s_cyc   = gnt1 ? i_m1_cyc   : i_m0_cyc;
    assign o_s_stb   = gnt1 ? i_m1_stb   : i_m0_stb;
    assign o_s_we    = gnt1 ? i_m1_we    : i_m0_we;
    assign o_s_addr  = gnt1 ? i_m1_addr  : i_m0_addr;
    assign o_s_wdata = gnt1 ? i_m1_wdata : i_m0_wdata;
    assign o_s_sel   = gnt1 ? i_m1_sel   : i_m0_sel;

    // Loser is stalled and sees no answer
    assign o_m0_stall = gnt1;
    assign o_m1_stall = !gnt1;
    assign o_m0_ack   = !gnt1 && i_s_ack;
    assign o_m1_ack   = gnt1 && i_s_ack;
    assign o_m0_err   = !gnt1 && i_s_err;
    assign o_m1_err   = gnt1 && i_s_err;
    assign o_m0_rdata = gnt1 ? '0 : i_s_rdata;
    assign o_m1_rdata = gnt1 ? i_s_rdata : '0;

endmodule

`default_nettype wire

// ==== rtl/wb_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_ram
    import bus_pkg::*;
(
    input  wire                  i_clk,
    input  wire                  i_rst,
    input  wire                  i_wb_cyc,
    input  wire                  i_wb_stb,
    input  wire                  i_wb_we,
    input  wire  [WB_ADDR_W-1:0] i_wb_addr,
    input  wire  [WB_DATA_W-1:0] i_wb_wdata,
    input  wire  [WB_SEL_W-1:0]  i_wb_sel,
    input  wire  [WB_DATA_W-1:0] i_io_in,
    output logic                 o_wb_ack,
    output logic                 o_wb_err,
    output logic [WB_DATA_W-1:0] o_wb_rdata,
    output logic [WB_DATA_W-1:0] o_io_out
);

    logic [WB_DATA_W-1:0] mem [RAM_WORDS];

    logic acc, hit_ram, hit_io;

    // Never stalls, so every strobe is accepted
    assign acc     = i_wb_cyc && i_wb_stb;
    assign hit_ram = (i_wb_addr < WB_ADDR_W'(RAM_WORDS));
    assign hit_io  = (i_wb_addr == IO_BASE);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_ack <= 1'b0;
            o_wb_err <= 1'b0;
            o_io_out <= '0;
        end else begin
            o_wb_ack <= acc && (hit_ram || hit_io);
            o_wb_err <= acc && !(hit_ram || hit_io);  // Unmapped address
            if (acc && i_wb_we && hit_io)
                o_io_out <= i_wb_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (acc && i_wb_we && hit_ram) begin
            for (int i = 0; i < WB_SEL_W; i++) begin
                if (i_wb_sel[i])
                    mem[i_wb_addr[RAM_AW-1:0]][i*8 +: 8] <= i_wb_wdata[i*8 +: 8];
            end
        end
        // IO input sampled at acceptance
        if (acc)
            o_wb_rdata <= hit_io ? i_io_in : mem[i_wb_addr[RAM_AW-1:0]];
    end

endmodule

`default_nettype wire

// ==== tests/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem
    import isa_pkg::*, bus_pkg::*;
();

    localparam int N_INSTR    = 70;               // Instructions plus fetches issued
    localparam int N_FETCH    = 10;
    localparam int MAX_CYCLES = 40 * N_INSTR + 200;
    localparam logic [31:0] ERR_WORD = 32'h1337_1337;

    logic                 i_clk, i_rst, i_pipe_stall, i_pipe_flush;
    logic                 o_pipe_stall, o_pipe_flush, o_ld_newpc;
    opcode_e              i_opcode;
    logic [REG_W-1:0]     i_dr, o_fwd_dr, o_buf_dr;
    logic [WB_DATA_W-1:0] i_sr1_val, i_sr2_val, i_imm, i_pc;
    logic [WB_DATA_W-1:0] o_fwd_val, o_buf_val, o_br_pc;
    logic                 i_fetch_req, o_fetch_valid, o_fetch_busy;
    logic [WB_ADDR_W-1:0] i_fetch_addr;
    logic [WB_DATA_W-1:0] o_fetch_data, i_io_in, o_io_out;

    integer               seed = 32'h96dc87c5;
    int                   cycle_cnt = 0;
    int                   fetch_count = 0;
    logic                 fetch_pending = 1'b0;
    logic [WB_DATA_W-1:0] fetch_exp;

    logic [WB_DATA_W-1:0] model [int];   // Word address to data
    int                   words [$];     // RAM words written so far

    // Captured at the result cycle
    logic [REG_W-1:0]     res_dr, fwd_dr;
    logic [WB_DATA_W-1:0] res_val, res_pc, fwd_val;
    logic                 res_newpc, res_flush;

    mem_subsystem_top mem_subsystem_top_inst (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_pipe_stall(i_pipe_stall), .i_pipe_flush(i_pipe_flush),
        .o_pipe_stall(o_pipe_stall), .o_pipe_flush(o_pipe_flush),
        .i_opcode(i_opcode), .i_dr(i_dr), .i_pc(i_pc),
        .i_sr1_val(i_sr1_val), .i_sr2_val(i_sr2_val), .i_imm(i_imm),
        .o_fwd_dr(o_fwd_dr), .o_fwd_val(o_fwd_val),
        .o_buf_dr(o_buf_dr), .o_buf_val(o_buf_val),
        .o_ld_newpc(o_ld_newpc), .o_br_pc(o_br_pc),
        .i_fetch_req(i_fetch_req), .i_fetch_addr(i_fetch_addr),
        .o_fetch_valid(o_fetch_valid), .o_fetch_data(o_fetch_data),
        .o_fetch_busy(o_fetch_busy), .i_io_in(i_io_in), .o_io_out(o_io_out)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    task automatic report_failure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            report_failure();
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // Issue one instruction and wait for its result cycle
    task automatic run_instr(input opcode_e op, input logic [REG_W-1:0] dr,
                             input logic [31:0] sr1, input logic [31:0] sr2,
                             input logic [31:0] imm, input logic [31:0] pc,
                             input int stall_cycles);
        @(negedge i_clk);
        i_opcode  = op;
        i_dr      = dr;
        i_sr1_val = sr1;
        i_sr2_val = sr2;
        i_imm     = imm;
        i_pc      = pc;
        @(posedge i_clk);
        expect_eq("o_pipe_stall", o_pipe_stall, 1'b1);  // Stalls from the first cycle
        @(negedge i_clk);
        i_opcode = OP_NOP;
        if (stall_cycles > 0) begin
            i_pipe_stall = 1'b1;
            repeat (stall_cycles) begin
                @(posedge i_clk);
                assert (o_buf_dr == '0 && o_fwd_dr == '0 && !o_ld_newpc)
                else begin
                    $display("Result delivered while the pipeline was stalled");
                    report_failure();
                end
            end
            @(negedge i_clk);
            i_pipe_stall = 1'b0;
        end
        fwd_dr = '0;
        do begin
            @(posedge i_clk);
            if (o_fwd_dr != '0) begin   // Ack cycle of a load
                fwd_dr  = o_fwd_dr;
                fwd_val = o_fwd_val;
            end
        end while (o_pipe_stall);
        res_dr    = o_buf_dr;
        res_val   = o_buf_val;
        res_newpc = o_ld_newpc;
        res_flush = o_pipe_flush;
        res_pc    = o_br_pc;
    endtask

    task automatic load_and_compare(input opcode_e op, input logic [REG_W-1:0] dr,
                                    input logic [31:0] sr1, input logic [31:0] imm,
                                    input logic [31:0] exp, input int stall_cycles);
        run_instr(op, dr, sr1, 32'h0, imm, 32'h0, stall_cycles);
        expect_eq("o_buf_dr", res_dr, dr);
        expect_eq("o_buf_val", res_val, exp);
        expect_eq("o_fwd_dr", fwd_dr, (stall_cycles > 0) ? '0 : dr);
        if (stall_cycles == 0)
            expect_eq("o_fwd_val", fwd_val, exp);
    endtask

    task automatic store_and_track(input opcode_e op, input logic [31:0] addr,
                                   input logic [31:0] data);
        logic [31:0] sr1;
        logic [31:0] word;
        sr1 = rand_word();
        run_instr(op, '0, sr1, data, addr - sr1, 32'h0, 0);
        expect_eq("o_buf_dr", res_dr, 0);
        if (op == OP_SB) begin
            word = model[int'(addr >> 2)];
            word[addr[1:0]*8 +: 8] = data[7:0];   // Only the addressed lane
            model[int'(addr >> 2)] = word;
        end else begin
            model[int'(addr >> 2)] = data;
        end
    endtask

    always @(posedge i_clk) begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYCLES) begin
            $display("Timeout after %0d cycles without finishing the test", cycle_cnt);
            report_failure();
        end
    end

    // Fetch results are checked as they arrive
    always @(posedge i_clk) begin
        if (!i_rst && o_fetch_valid) begin
            assert (fetch_pending)
            else begin
                $display("Fetch data returned with no request outstanding");
                report_failure();
            end
            expect_eq("o_fetch_data", o_fetch_data, fetch_exp);
            expect_eq("o_fetch_busy", o_fetch_busy, 1'b0);  // Back to idle with the data
            fetch_pending = 1'b0;
            fetch_count++;
        end
    end

    initial begin
        logic [31:0] data, sr1, sr2, imm, pc, base;
        logic [7:0]  b;
        int          w, fw;
        i_rst        = 1'b1;
        i_pipe_stall = 1'b0;
        i_pipe_flush = 1'b0;
        i_opcode     = OP_NOP;
        i_dr         = '0;
        i_sr1_val    = '0;
        i_sr2_val    = '0;
        i_imm        = '0;
        i_pc         = '0;
        i_fetch_req  = 1'b0;
        i_fetch_addr = '0;
        i_io_in      = '0;
        repeat (3) @(negedge i_clk);
        i_rst = 1'b0;
        @(posedge i_clk);
        expect_eq("o_pipe_stall", o_pipe_stall, 1'b0);
        expect_eq("o_pipe_flush", o_pipe_flush, 1'b0);
        expect_eq("o_ld_newpc", o_ld_newpc, 1'b0);
        expect_eq("o_buf_dr", o_buf_dr, 0);

        repeat (12) begin
            w = rand_word() % RAM_WORDS;
            words.push_back(w);
            store_and_track(OP_SW, w * 4, rand_word());
        end
        foreach (words[i]) begin
            sr1 = rand_word();
            load_and_compare(OP_LW, 4'(1 + i % 15), sr1, words[i] * 4 - sr1, model[words[i]], 0);
        end

        // Byte lanes of one word
        w    = words[0];
        base = w * 4;
        for (int lane = 0; lane < 4; lane++) begin
            data    = rand_word();
            data[7] = lane[0];                  // Both signs for LBSE
            store_and_track(OP_SB, base + lane, data);
            b   = model[w][lane*8 +: 8];
            sr1 = rand_word();
            load_and_compare(OP_LB, 4'd3, sr1, base + lane - sr1, {24'h0, b}, 0);
            load_and_compare(OP_LBSE, 4'd4, sr1, base + lane - sr1, {{24{b[7]}}, b}, 0);
            load_and_compare(OP_LW, 4'd5, 32'h0, base, model[w], 0);  // Other lanes kept
        end

        data = rand_word();
        run_instr(OP_OUT, '0, data, 32'h0, 32'h0, 32'h0, 0);
        expect_eq("o_io_out", o_io_out, data);
        @(negedge i_clk);
        i_io_in = rand_word();
        load_and_compare(OP_IN, 4'd6, 32'h0, 32'h0, i_io_in, 0);

        sr2 = 4 + 4 * (rand_word() % 255);     // Stack slot inside RAM
        sr1 = rand_word();
        imm = rand_word();
        pc  = rand_word() & ~32'h3;
        run_instr(OP_CALL, '0, sr1, sr2, imm, pc, 0);
        expect_eq("o_ld_newpc", res_newpc, 1'b1);
        expect_eq("o_pipe_flush", res_flush, 1'b1);
        expect_eq("o_br_pc", res_pc, sr1 + imm);
        model[int'((sr2 - 4) >> 2)] = pc + 4;
        run_instr(OP_RET, '0, 32'h0, sr2 - 4, 32'h0, 32'h0, 0);
        expect_eq("o_ld_newpc", res_newpc, 1'b1);
        expect_eq("o_pipe_flush", res_flush, 1'b1);
        expect_eq("o_br_pc", res_pc, model[int'((sr2 - 4) >> 2)]);

        load_and_compare(OP_LW, 4'd7, 32'h0, 32'h0000_2000, ERR_WORD, 0);  // Unmapped
        sr1 = rand_word();
        load_and_compare(OP_LW, 4'd8, sr1, words[1] * 4 - sr1, model[words[1]], 8);

        // Fetches overlapping memory stage loads
        fork
            repeat (N_FETCH) begin
                @(negedge i_clk);
                while (fetch_pending) @(negedge i_clk);
                fw            = words[rand_word() % words.size()];
                fetch_exp     = model[fw];
                fetch_pending = 1'b1;
                i_fetch_req   = 1'b1;
                i_fetch_addr  = WB_ADDR_W'(fw);
                @(negedge i_clk);
                i_fetch_req = 1'b0;
                expect_eq("o_fetch_busy", o_fetch_busy, 1'b1);
            end
            foreach (words[i])
                load_and_compare(OP_LW, 4'(1 + i % 15), 32'h100 * i,
                                 words[i] * 4 - 32'h100 * i, model[words[i]], 0);
        join
        while (fetch_pending) @(negedge i_clk);

        if (fetch_count != N_FETCH) begin
            $display("Error: fetch_count = %h, expected %h", fetch_count, N_FETCH);
            report_failure();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

`default_nettype wire
